//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_z80_bus
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' list.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^STATUS: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
source/z80_bus_pkg.sv
source/z80_cycle_if.sv
source/z80_bus_sampler.sv
source/z80_mem_bridge.sv
source/z80_port_bridge.sv
source/z80_data_driver.sv
source/z80_bus_top.sv
sim/z80_bus_assert.sv
sim/tb_z80_bus.sv

//--- sim/tb_z80_bus.sv
// Assumes default top parameters with bank 2, 192 KB RAM, read WAIT delay 2 and ports F0 to F9
`default_nettype none

module tb_z80_bus import z80_bus_pkg::*; ();

   localparam int K_WR = 0, K_RD = 1, K_FETCH = 2, K_PWR = 3, K_PRD = 4;

   typedef struct {
      int        kind;                  // Z80 cycle type
      z80_addr_t addr;
      byte_t     wdata;
      int        dly;                   // Ready delay or busy cycles with -1 for random
      byte_t     expd;                  // Expected read byte
      bit        hit;                   // Request or strobe expected
   } vec_t;

   logic      CMD_CLK, reset, z80_clk, z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n;
   z80_addr_t z80_addr;
   byte_t     z80_data_in, z80_data_out, ram_write_data, ram_read_data;
   byte_t     port_wr_data, port_rd_data, last_wdata, last_pdata;
   logic      z80_data_oe, z80_wait, buf_dir_out, buf_oe_n, ram_w_busy, ram_write_req;
   logic      ram_read_req, ram_read_ready, port_wr_strobe, port_rd_strobe;
   ram_addr_t ram_waddr, ram_raddr, last_waddr;
   port_t     port_addr, last_port;
   byte_t     ram_mem [int];            // RAM model
   vec_t      tbl [13];
   int        errors = 0, timeouts = 0, wr_cnt = 0, pw_cnt = 0, pr_cnt = 0;
   int        oe_cnt = 0, rdq_cnt = 0;  // Cycles with z80_data_oe or ram_read_req high

   z80_bus_top z80_bus_top_inst (.*);

   assign port_rd_data = port_addr ^ 8'ha5; // Port read model

   initial begin
      CMD_CLK = 1'b0;
      forever #50 CMD_CLK = ~CMD_CLK;
   end

   initial begin
      z80_clk = 1'b0;
      forever begin
         repeat (4) @(posedge CMD_CLK);
         #10 z80_clk = ~z80_clk;        // Z80 clock at CMD_CLK / 8
      end
   end

   // Bus monitor that also stores RAM writes
   always @(posedge CMD_CLK) begin
      if (ram_write_req) begin
         wr_cnt++;
         ram_mem[int'(ram_waddr)] = ram_write_data;
         last_waddr = ram_waddr;
         last_wdata = ram_write_data;
      end
      if (port_wr_strobe) begin
         pw_cnt++;
         last_port  = port_addr;
         last_pdata = port_wr_data;
      end
      if (port_rd_strobe) pr_cnt++;
      if (z80_data_oe)    oe_cnt++;
      if (ram_read_req)   rdq_cnt++;
   end

   task automatic tick;
      @(posedge CMD_CLK);
      #10;
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input bit ok, input string what);
      assert (ok) else begin
         $display("Error: %s", what);
         errors++;
      end
   endtask

   task automatic timed_out(input string what);
      $display("Timeout while waiting for %s", what);
      timeouts++;
   endtask

   task automatic wait_oe(input logic level);
      int n;
      n = 0;
      while (z80_data_oe !== level && n < 200) begin
         tick();
         n++;
      end
      if (z80_data_oe !== level) timed_out("z80_data_oe to change");
   endtask

   // ****************************************
   // One Z80 cycle per table entry
   // ****************************************
   task automatic run_entry(input int i);
      vec_t v;
      int   n, d, tap, start_w, start_pw, start_pr, start_oe, start_rq;
      bit   saw_wait;
      v = tbl[i];
      d = (v.dly < 0) ? int'($urandom_range(7, 1)) : v.dly;
      start_w  = wr_cnt;
      start_pw = pw_cnt;
      start_pr = pr_cnt;
      start_oe = oe_cnt;
      start_rq = rdq_cnt;
      saw_wait = 1'b0;
      z80_addr    = v.addr;
      z80_data_in = v.wdata;
      if (v.kind == K_WR && d > 0) ram_w_busy = 1'b1;
      z80_m1_n   = !(v.kind == K_FETCH);
      z80_mreq_n = !(v.kind <= K_FETCH);
      z80_iorq_n = !(v.kind >= K_PWR);
      z80_rd_n   = !(v.kind == K_RD || v.kind == K_FETCH || v.kind == K_PRD);
      z80_wr_n   = !(v.kind == K_WR || v.kind == K_PWR);
      case (v.kind)
         K_WR: begin
            for (n = 0; n < d; n++) begin
               tick();
               if (z80_wait) saw_wait = 1'b1;
            end
            if (d > 0) begin
               check_flag(saw_wait, "z80_wait not raised while RAM write busy");
               check_flag(wr_cnt == start_w, "write request issued while RAM busy");
               ram_w_busy = 1'b0;
            end
            n = 0;
            while (v.hit && wr_cnt == start_w && n < 200) begin
               tick();
               n++;
            end
            if (v.hit && wr_cnt == start_w) timed_out("ram_write_req");
            repeat (30) tick();
            if (v.hit) begin
               check_val("ram_waddr", last_waddr, v.addr[19:0]);
               check_val("ram_write_data", last_wdata, v.wdata);
            end
            check_val("ram_write_req count", wr_cnt - start_w, v.hit);
         end
         K_RD, K_FETCH: begin
            if (v.hit) begin
               n = 0;
               while (!ram_read_req && n < 200) begin
                  tick();
                  n++;
               end
               if (!ram_read_req) timed_out("ram_read_req");
               check_val("ram_raddr", ram_raddr, v.addr[19:0]);
               tap = (v.kind == K_FETCH) ? 0 : 2;
               for (n = 0; n < d; n++) begin
                  tick();
                  if (z80_wait) saw_wait = 1'b1;
               end
               if (d > tap + 1) check_flag(saw_wait, "z80_wait not seen before RAM ready");
               ram_read_data  = ram_mem.exists(int'(ram_raddr)) ? ram_mem[int'(ram_raddr)]
                                                                : 8'h00;
               ram_read_ready = 1'b1;
               tick();
               ram_read_ready = 1'b0;
               check_val("z80_wait", z80_wait, 1'b0);
            end
            wait_oe(1'b1);
            check_val("z80_data_out", z80_data_out, v.expd);
            if (!v.hit) check_flag(rdq_cnt == start_rq, "RAM read request for a local read");
         end
         K_PWR: begin
            n = 0;
            while (pw_cnt == start_pw && n < 200) begin
               tick();
               n++;
            end
            if (pw_cnt == start_pw) timed_out("port_wr_strobe");
            check_val("port_addr", last_port, v.addr[7:0]);
            check_val("port_wr_data", last_pdata, v.wdata);
         end
         default: begin
            if (v.hit) begin
               wait_oe(1'b1);
               check_val("z80_data_out", z80_data_out, v.addr[7:0] ^ 8'ha5);
            end else begin
               repeat (40) tick();
               check_flag(oe_cnt == start_oe, "z80_data_oe raised for a port outside the range");
            end
         end
      endcase
      {z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n} = 5'b11111; // Back to idle
      wait_oe(1'b0);
      repeat (32) tick();
      check_val("port_wr_strobe count", pw_cnt - start_pw, v.kind == K_PWR);
      check_val("port_rd_strobe count", pr_cnt - start_pr, v.kind == K_PRD && v.hit);
   endtask

   initial begin
      void'($urandom(34831));
      tbl[0]  = '{K_WR,    22'h100123, 8'h3c, 0,  8'h00, 1'b1};
      tbl[1]  = '{K_WR,    22'h100456, 8'h5a, 5,  8'h00, 1'b1}; // Busy RAM
      tbl[2]  = '{K_WR,    22'h0c0010, 8'h77, 0,  8'h00, 1'b0}; // Other bank
      tbl[3]  = '{K_WR,    22'h140000, 8'h11, 0,  8'h00, 1'b0}; // Above RAM size
      tbl[4]  = '{K_RD,    22'h100123, 8'h00, 1,  8'h3c, 1'b1};
      tbl[5]  = '{K_FETCH, 22'h100456, 8'h00, -1, 8'h5a, 1'b1};
      tbl[6]  = '{K_RD,    22'h100456, 8'h00, 6,  8'h5a, 1'b1}; // Long ready delay
      tbl[7]  = '{K_RD,    22'h150000, 8'h00, 0,  8'hff, 1'b0};
      tbl[8]  = '{K_RD,    22'h17fff2, 8'h00, 0,  8'd71, 1'b0}; // Identity window
      tbl[9]  = '{K_FETCH, 22'h17fff9, 8'h00, 0,  8'd67, 1'b0};
      tbl[10] = '{K_PWR,   22'h000031, 8'hc3, 0,  8'h00, 1'b1};
      tbl[11] = '{K_PRD,   22'h0000f3, 8'h00, 0,  8'h00, 1'b1};
      tbl[12] = '{K_PRD,   22'h000010, 8'h00, 0,  8'h00, 1'b0}; // Outside port range
      reset = 1'b1;
      {z80_m1_n, z80_mreq_n, z80_iorq_n, z80_rd_n, z80_wr_n} = 5'b11111;
      z80_addr = '0;
      z80_data_in = '0;
      ram_w_busy = 1'b0;
      ram_read_ready = 1'b0;
      ram_read_data = '0;
      repeat (8) tick();
      check_val("z80_data_oe", z80_data_oe, 1'b0);
      check_val("buf_dir_out", buf_dir_out, 1'b0);
      check_val("z80_wait", z80_wait, 1'b0);
      check_val("ram_write_req", ram_write_req, 1'b0);
      check_val("port_rd_strobe", port_rd_strobe, 1'b0);
      check_val("port_wr_strobe", port_wr_strobe, 1'b0);
      check_val("buf_oe_n", buf_oe_n, 1'b1);
      reset = 1'b0;
      repeat (2) tick();
      check_val("buf_oe_n", buf_oe_n, 1'b0); // Bus seen idle
      for (int i = 0; i < 13; i++) run_entry(i);
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/z80_bus_assert.sv
// Bound to z80_bus_top; checks hold only outside reset, and all failures come out as $error
`default_nettype none

module z80_bus_assert (
   input logic CMD_CLK,
   input logic reset,
   input logic ram_write_req,
   input logic z80_data_oe,
   input logic buf_dir_out,
   input logic port_wr_strobe,
   input logic port_rd_strobe
);

   // ****************************************
   // Handshake and strobe shape
   // ****************************************
   wreq_single: assert property (@(posedge CMD_CLK) disable iff (reset)
      ram_write_req |=> !ram_write_req) else $error("ram_write_req held two cycles");

   oe_dir: assert property (@(posedge CMD_CLK) disable iff (reset)
      z80_data_oe |-> buf_dir_out) else $error("z80_data_oe without buf_dir_out");

   pwr_single: assert property (@(posedge CMD_CLK) disable iff (reset)
      port_wr_strobe |=> !port_wr_strobe) else $error("port_wr_strobe longer than one cycle");

   prd_single: assert property (@(posedge CMD_CLK) disable iff (reset)
      port_rd_strobe |=> !port_rd_strobe) else $error("port_rd_strobe longer than one cycle");

endmodule

bind z80_bus_top z80_bus_assert z80_bus_assert_inst (.*);

`default_nettype wire

//--- source/z80_bus_pkg.sv
// Assumes a 22-bit Z80 address with a 512 KB bank window; the RAM sees only the low 20 bits
`default_nettype none

package z80_bus_pkg;

   // ****************************************
   // Bus widths
   // ****************************************
   typedef logic [21:0] z80_addr_t;     // Full Z80 address incl. extended bits
   typedef logic [19:0] ram_addr_t;     // Byte address toward RAM
   typedef logic [7:0]  byte_t;         // Data byte
   typedef logic [7:0]  port_t;         // IO port number, low address byte
   typedef logic [3:0]  ck_pos_t;       // Z80 clock half-phase count in a cycle

   // ****************************************
   // Decoded bus cycle
   // ****************************************
   typedef enum logic [2:0] {
      cyc_idle,                         // MREQ and IORQ both inactive
      cyc_fetch,                        // M1 opcode fetch
      cyc_mem_rd,                       // Memory read
      cyc_mem_wr,                       // Memory write
      cyc_port_rd,                      // IO read
      cyc_port_wr,                      // IO write
      cyc_other                         // Refresh, INTA and anything odd
   } bus_op_t;

   // Identity bytes returned in the 16-byte bank ID window
   localparam byte_t bank_id_table [16] = '{
      8'd9,  8'd3,  8'd71, 8'd80,
      8'd85, 8'd32, 8'd69, 8'd80,
      8'd52, 8'd67, 8'd69, 8'd49,
      8'd48, 8'd0,  8'd255, 8'd255
   };

endpackage

`default_nettype wire

//--- source/z80_bus_sampler.sv
// Z80 inputs are asynchronous to CMD_CLK and sampled once; CMD_CLK must run well above 2x z80_clk
`default_nettype none

module z80_bus_sampler import z80_bus_pkg::*; (
   input  logic      CMD_CLK,
   input  logic      reset,
   input  logic      z80_clk,
   input  z80_addr_t z80_addr,
   input  logic      z80_m1_n,
   input  logic      z80_mreq_n,
   input  logic      z80_iorq_n,
   input  logic      z80_rd_n,
   input  logic      z80_wr_n,
   input  byte_t     z80_data_in,
   z80_cycle_if.sampler cyc
);

   logic      clk_r;                    // Z80 clock, first stage
   logic      clk_r2;                   // Z80 clock, second stage
   logic      m1_n_r;
   logic      mreq_n_r;
   logic      iorq_n_r;
   logic      rd_n_r;
   logic      wr_n_r;
   z80_addr_t addr_r;
   byte_t     data_r;
   ck_pos_t   ck_pos_r;
   bus_op_t   op_dec;
   logic      zclk_edge;

   // ****************************************
   // Input registers
   // ****************************************
   always_ff @(posedge CMD_CLK) begin
      addr_r <= z80_addr;               // Payload, no reset
      data_r <= z80_data_in;
   end

   always_ff @(posedge CMD_CLK) begin
      if (reset) begin
         clk_r    <= 1'b0;
         clk_r2   <= 1'b0;
         m1_n_r   <= 1'b1;              // All controls inactive
         mreq_n_r <= 1'b1;
         iorq_n_r <= 1'b1;
         rd_n_r   <= 1'b1;
         wr_n_r   <= 1'b1;
      end else begin
         clk_r    <= z80_clk;
         clk_r2   <= clk_r;
         m1_n_r   <= z80_m1_n;
         mreq_n_r <= z80_mreq_n;
         iorq_n_r <= z80_iorq_n;
         rd_n_r   <= z80_rd_n;
         wr_n_r   <= z80_wr_n;
      end
   end

   assign zclk_edge = clk_r ^ clk_r2;   // Either Z80 clock transition

   // Cycle decode from the active-low controls
   always_comb begin
      if (mreq_n_r && iorq_n_r)                              op_dec = cyc_idle;
      else if (!m1_n_r && iorq_n_r && !mreq_n_r && !rd_n_r && wr_n_r) op_dec = cyc_fetch;
      else if (m1_n_r && iorq_n_r && !mreq_n_r && !rd_n_r && wr_n_r)  op_dec = cyc_mem_rd;
      else if (m1_n_r && iorq_n_r && !mreq_n_r && rd_n_r && !wr_n_r)  op_dec = cyc_mem_wr;
      else if (m1_n_r && !iorq_n_r && mreq_n_r && !rd_n_r && wr_n_r)  op_dec = cyc_port_rd;
      else if (m1_n_r && !iorq_n_r && mreq_n_r && rd_n_r && !wr_n_r)  op_dec = cyc_port_wr;
      else                                                   op_dec = cyc_other;
   end

   // Clock position within the cycle, restarts every idle
   always_ff @(posedge CMD_CLK) begin
      if (reset)                   ck_pos_r <= '0;
      else if (op_dec == cyc_idle) ck_pos_r <= '0;
      else if (zclk_edge)          ck_pos_r <= ck_pos_r + 1'b1;
   end

   assign cyc.op          = op_dec;
   assign cyc.addr        = addr_r;
   assign cyc.wdata       = data_r;
   assign cyc.zclk_edge   = zclk_edge;
   assign cyc.ck_pos      = ck_pos_r;
   assign cyc.mreq_active = !mreq_n_r;

endmodule

`default_nettype wire

//--- source/z80_bus_top.sv
// Data pin is split into in, out and enable; the board or a wrapper makes the tri-state
`default_nettype none

module z80_bus_top import z80_bus_pkg::*; #(
   parameter bit [2:0]    mem_range          = 3'b010,
   parameter int unsigned mem_size_bytes     = 196608,
   parameter bit          bank_response      = 1'b1,
   parameter bit [14:0]   bank_id_addr       = 15'h7fff,
   parameter bit [2:0]    wait_delay_fetch   = 3'd0,
   parameter bit [2:0]    wait_delay_read    = 3'd2,
   parameter ck_pos_t     read_port_clk_pos  = 4'd2,
   parameter ck_pos_t     write_port_clk_pos = 4'd2,
   parameter port_t       read_port_begin    = 8'd240,
   parameter port_t       read_port_end      = 8'd249
) (
   input  logic      CMD_CLK,
   input  logic      reset,
   // Z80 bus
   input  logic      z80_clk,
   input  z80_addr_t z80_addr,
   input  logic      z80_m1_n,
   input  logic      z80_mreq_n,
   input  logic      z80_iorq_n,
   input  logic      z80_rd_n,
   input  logic      z80_wr_n,
   input  byte_t     z80_data_in,
   output byte_t     z80_data_out,
   output logic      z80_data_oe,
   output logic      z80_wait,          // High pulls the Z80 WAIT line low
   output logic      buf_dir_out,       // High drives toward the Z80
   output logic      buf_oe_n,
   // RAM request port
   input  logic      ram_w_busy,
   output ram_addr_t ram_waddr,
   output logic      ram_write_req,
   output byte_t     ram_write_data,
   output ram_addr_t ram_raddr,
   output logic      ram_read_req,
   input  logic      ram_read_ready,
   input  byte_t     ram_read_data,
   // IO port bus
   output port_t     port_addr,
   output logic      port_wr_strobe,
   output byte_t     port_wr_data,
   output logic      port_rd_strobe,
   input  byte_t     port_rd_data
);

   logic  mem_load;
   byte_t mem_byte;
   logic  port_load;
   byte_t port_byte;

   z80_cycle_if cyc_if ();

   z80_bus_sampler z80_bus_sampler_inst (
      .CMD_CLK, .reset, .z80_clk, .z80_addr, .z80_m1_n, .z80_mreq_n,
      .z80_iorq_n, .z80_rd_n, .z80_wr_n, .z80_data_in, .cyc (cyc_if.sampler)
   );

   z80_mem_bridge #(
      .mem_range (mem_range), .mem_size_bytes (mem_size_bytes),
      .bank_response (bank_response), .bank_id_addr (bank_id_addr),
      .wait_delay_fetch (wait_delay_fetch), .wait_delay_read (wait_delay_read)
   ) z80_mem_bridge_inst (
      .CMD_CLK, .reset, .cyc (cyc_if.consumer), .ram_w_busy, .ram_waddr, .ram_write_req,
      .ram_write_data, .ram_raddr, .ram_read_req, .ram_read_ready, .ram_read_data,
      .z80_wait, .mem_load, .mem_byte
   );

   z80_port_bridge #(
      .read_port_clk_pos (read_port_clk_pos), .write_port_clk_pos (write_port_clk_pos),
      .read_port_begin (read_port_begin), .read_port_end (read_port_end)
   ) z80_port_bridge_inst (
      .CMD_CLK, .reset, .cyc (cyc_if.consumer), .port_addr, .port_wr_strobe,
      .port_wr_data, .port_rd_strobe, .port_rd_data, .port_load, .port_byte
   );

   z80_data_driver z80_data_driver_inst (
      .CMD_CLK, .reset, .cyc (cyc_if.driver), .mem_load, .mem_byte, .port_load,
      .port_byte, .z80_data_out, .z80_data_oe, .buf_dir_out, .buf_oe_n
   );

endmodule

`default_nettype wire

//--- source/z80_cycle_if.sv
// Carries the bus view one CMD_CLK behind the pins; all signals are driven by the sampler only
`default_nettype none

interface z80_cycle_if import z80_bus_pkg::*; ();

   bus_op_t   op;                       // Decoded cycle type
   z80_addr_t addr;                     // Sampled address
   byte_t     wdata;                    // Sampled data from the Z80
   logic      zclk_edge;                // One-cycle pulse per Z80 clock transition
   ck_pos_t   ck_pos;                   // Half-phase count since cycle start
   logic      mreq_active;              // MREQ asserted

   modport sampler (
      output op, addr, wdata, zclk_edge, ck_pos, mreq_active
   );

   modport consumer (
      input op, addr, wdata, zclk_edge, ck_pos, mreq_active
   );

   // Driver only needs to know when the bus goes idle
   modport driver (
      input op
   );

endinterface

`default_nettype wire

//--- source/z80_data_driver.sv
// Level shifter stays disabled until the bus is first seen idle after reset
`default_nettype none

module z80_data_driver import z80_bus_pkg::*; (
   input  logic  CMD_CLK,
   input  logic  reset,
   z80_cycle_if.driver cyc,
   input  logic  mem_load,
   input  byte_t mem_byte,
   input  logic  port_load,
   input  byte_t port_byte,
   output byte_t z80_data_out,
   output logic  z80_data_oe,
   output logic  buf_dir_out,
   output logic  buf_oe_n
);

   // ****************************************
   // Output enable and buffer control
   // ****************************************
   always_ff @(posedge CMD_CLK) begin
      if (reset) begin
         z80_data_oe <= 1'b0;
         buf_dir_out <= 1'b0;           // Toward the FPGA
         buf_oe_n    <= 1'b1;           // Buffer off
      end else if (cyc.op == cyc_idle) begin
         z80_data_oe <= 1'b0;           // Release the bus
         buf_dir_out <= 1'b0;
         buf_oe_n    <= 1'b0;           // Bus known idle, buffer on for good
      end else if (mem_load || port_load) begin
         z80_data_oe <= 1'b1;
         buf_dir_out <= 1'b1;           // Toward the Z80
      end
   end

   // Outgoing byte, memory and port loads never overlap
   always_ff @(posedge CMD_CLK) begin
      if (mem_load)       z80_data_out <= mem_byte;
      else if (port_load) z80_data_out <= port_byte;
   end

endmodule

`default_nettype wire

//--- source/z80_mem_bridge.sv
// RAM must return exactly one ram_read_ready per held ram_read_req; WAIT delays are 0 to 7 CMD_CLKs
`default_nettype none

module z80_mem_bridge import z80_bus_pkg::*; #(
   parameter bit [2:0]    mem_range        = 3'b010,         // Bank select on addr[21:19]
   parameter int unsigned mem_size_bytes   = 196608,         // RAM size inside the bank
   parameter bit          bank_response    = 1'b1,           // Answer identity reads
   parameter bit [14:0]   bank_id_addr     = 15'h7fff,       // Identity window, addr[18:4]
   parameter bit [2:0]    wait_delay_fetch = 3'd0,
   parameter bit [2:0]    wait_delay_read  = 3'd2
) (
   input  logic      CMD_CLK,
   input  logic      reset,
   z80_cycle_if.consumer cyc,
   input  logic      ram_w_busy,
   output ram_addr_t ram_waddr,
   output logic      ram_write_req,
   output byte_t     ram_write_data,
   output ram_addr_t ram_raddr,
   output logic      ram_read_req,
   input  logic      ram_read_ready,
   input  byte_t     ram_read_data,
   output logic      z80_wait,
   output logic      mem_load,
   output byte_t     mem_byte
);

   logic       in_bank;
   logic       in_range;
   logic       in_id;
   logic       is_read;
   logic       local_rd;                // In-bank read answered without RAM
   logic       r_sent;                  // Read data taken this cycle
   logic       w_sent;                  // Write issued this cycle
   logic       wait_enable;
   logic       wait_tap;
   logic [7:0] wait_pipe;               // Bit 0 fixed high for zero delay
   byte_t      rd_byte;

   // ****************************************
   // Address decode
   // ****************************************
   assign in_bank  = (cyc.addr[21:19] == mem_range);
   assign in_range = in_bank && ({13'd0, cyc.addr[18:0]} < mem_size_bytes);
   assign in_id    = in_bank && (cyc.addr[18:4] == bank_id_addr);
   assign is_read  = (cyc.op == cyc_fetch) || (cyc.op == cyc_mem_rd);
   assign local_rd = is_read && in_bank && !in_range && !r_sent;

   // Requests straight off the sampled view
   assign ram_raddr      = cyc.addr[19:0];
   assign ram_read_req   = is_read && in_range && !r_sent;
   assign ram_waddr      = cyc.addr[19:0];
   assign ram_write_data = cyc.wdata;
   assign ram_write_req  = (cyc.op == cyc_mem_wr) && in_range && !ram_w_busy && !w_sent;

   always_ff @(posedge CMD_CLK) begin
      if (reset || cyc.op == cyc_idle) begin
         r_sent <= 1'b0;                // Cleared at end of cycle
         w_sent <= 1'b0;
      end else begin
         if ((ram_read_req && ram_read_ready) || local_rd) r_sent <= 1'b1;
         if (ram_write_req)                                w_sent <= 1'b1;
      end
   end

   // Read byte priority: RAM, identity table, then open bus FF
   always_comb begin
      if (in_range)                    rd_byte = ram_read_data;
      else if (bank_response && in_id) rd_byte = bank_id_table[cyc.addr[3:0]];
      else                             rd_byte = 8'hff;
   end

   always_ff @(posedge CMD_CLK) begin
      if (reset) mem_load <= 1'b0;
      else       mem_load <= (ram_read_req && ram_read_ready) || local_rd;
   end

   always_ff @(posedge CMD_CLK) begin
      mem_byte <= rd_byte;              // Qualified by mem_load downstream
   end

   // ****************************************
   // WAIT generation
   // ****************************************
   assign wait_enable = (ram_read_req && !ram_read_ready) ||
                        (ram_w_busy && in_bank && cyc.mreq_active);

   always_ff @(posedge CMD_CLK) begin
      if (reset) wait_pipe <= '0;
      else       wait_pipe <= {wait_pipe[6:1], wait_enable, 1'b1};
   end

   // Fetch gets its own delay, opcodes are most timing critical
   assign wait_tap = (cyc.op == cyc_fetch) ? wait_pipe[wait_delay_fetch]
                                           : wait_pipe[wait_delay_read];
   assign z80_wait = wait_enable && wait_tap; // Drops as soon as ready shows

endmodule

`default_nettype wire

//--- source/z80_port_bridge.sv
// Port data is taken at one Z80 clock position; no WAIT is ever raised for IO cycles
`default_nettype none

module z80_port_bridge import z80_bus_pkg::*; #(
   parameter ck_pos_t read_port_clk_pos  = 4'd2,  // Position of the read response
   parameter ck_pos_t write_port_clk_pos = 4'd2,  // Position of the write data sample
   parameter port_t   read_port_begin    = 8'd240,
   parameter port_t   read_port_end      = 8'd249
) (
   input  logic  CMD_CLK,
   input  logic  reset,
   z80_cycle_if.consumer cyc,
   output port_t port_addr,
   output logic  port_wr_strobe,
   output byte_t port_wr_data,
   output logic  port_rd_strobe,
   input  byte_t port_rd_data,
   output logic  port_load,
   output byte_t port_byte
);

   logic is_port;
   logic rd_in_range;
   logic wr_hit;
   logic rd_hit;

   assign is_port     = (cyc.op == cyc_port_rd) || (cyc.op == cyc_port_wr);
   assign rd_in_range = (cyc.addr[7:0] >= read_port_begin) && (cyc.addr[7:0] <= read_port_end);

   // One hit per cycle since ck_pos moves on after the edge
   assign wr_hit = (cyc.op == cyc_port_wr) && cyc.zclk_edge && (cyc.ck_pos == write_port_clk_pos);
   assign rd_hit = (cyc.op == cyc_port_rd) && cyc.zclk_edge && (cyc.ck_pos == read_port_clk_pos)
                   && rd_in_range;

   always_ff @(posedge CMD_CLK) begin
      if (reset) begin
         port_wr_strobe <= 1'b0;
         port_rd_strobe <= 1'b0;
         port_load      <= 1'b0;
      end else begin
         port_wr_strobe <= wr_hit;
         port_rd_strobe <= rd_hit;
         port_load      <= rd_hit;      // Read byte goes to the data driver
      end
   end

   always_ff @(posedge CMD_CLK) begin
      if (is_port) port_addr    <= cyc.addr[7:0]; // Valid ahead of the strobe
      if (wr_hit)  port_wr_data <= cyc.wdata;
      if (rd_hit)  port_byte    <= port_rd_data;
   end

endmodule

`default_nettype wire
